// ==== verilog.f ====
+incdir+hw
hw/isaPkg.sv
hw/corePkg.sv
hw/regBlock.sv
hw/execUnit.sv
hw/instrSequencer.sv
hw/cpuTop.sv
sim/cpuTop_chk.sv
sim/cpuTop_tb.sv

// ==== sim/cpuTop_tb.sv ====
`timescale 1ns/1ns
`include "cpu_config.svh"

// Random programs checked against an ISA model, memory answers with random latency
module cpuTop_tb;

  localparam int Programs = 20;
  localparam int ProgLen = 30;               // Instructions per program
  localparam int ResetCycles = 16;
  localparam int MemWords = 1024;
  localparam logic [31:0] CodeBase = 32'h100;  // Stack grows up from 0 below it
  localparam logic [31:0] SubBase = 32'h600;   // Shared subroutine
  localparam logic [31:0] DataBase = 32'h800;
  // About 20 cycles per instruction at worst, plus reset and the idle tail
  localparam int TimeoutCycles = Programs * ((ProgLen + 1) * 20 + ResetCycles + 8);

  logic clk = 1'b0;
  logic reset;
  corePkg::memStatusT memStatus;
  logic [`WORD_W-1:0] memRData;
  logic memRead, memWrite, halted;
  logic [`WORD_W-1:0] memAddr, memWData, haltData;
  corePkg::haltCodeT haltCode;

  logic [31:0] seed;
  logic [31:0] mem [MemWords];     // Memory seen by the DUT
  logic [31:0] refMem [MemWords];  // Model copy
  logic [31:0] genPc;
  int genCount;
  bit expWrite [$];                // Expected requests in issue order
  logic [31:0] expAddr [$];
  logic [31:0] expData [$];
  logic [31:0] expHaltCode, expHaltData;
  int waitCount = 0;               // Cycles left until the response
  logic reqWrite;
  logic [31:0] reqAddr, reqData;
  bit ew;
  logic [31:0] ea, ed;
  int cycles = 0;

  cpuTop u_cpuTop (
    .clk, .reset, .memRead, .memWrite, .memAddr, .memWData, .memStatus, .memRData,
    .halted, .haltCode, .haltData
  );

  bind cpuTop cpuTop_chk u_chk (.clk, .reset, .memRead, .memWrite, .halted);

  always #10 clk = ~clk;

  task automatic compareValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERR %s expected %h actual %h", name, expected, actual);
      $display("RESULT: FAIL");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  function automatic logic [7:0] regField();
    return $random(seed);  // Upper nibble is noise, core uses the low 4 bits
  endfunction

  function automatic bit isLongOp(input isaPkg::opcodeT op);
    return op inside {isaPkg::MovRC, isaPkg::MovRdC, isaPkg::MovdCR, isaPkg::AddRRC,
                      isaPkg::JmpC, isaPkg::JeC, isaPkg::JneC, isaPkg::JzRC};
  endfunction

  // Short register op: MovRR or AddRRR through ShrRRR
  function automatic isaPkg::opcodeT aluOp();
    int r;
    r = {$random(seed)} % 5;
    return (r == 0) ? isaPkg::MovRR : isaPkg::opcodeT'(int'(isaPkg::AddRRR) + r - 1);
  endfunction

  task automatic emit(input isaPkg::opcodeT op, input logic [7:0] a, input logic [7:0] b,
                      input logic [31:0] data);
    mem[genPc[11:2]] = {regField(), b, a, op};
    if (isLongOp(op)) begin
      mem[genPc[11:2] + 10'd1] = data;
    end
    genPc = genPc + (isLongOp(op) ? `LONG_INSTR_BYTES : `INSTR_BYTES);
    genCount++;
  endtask

  task automatic buildProgram(input bit withFault);
    int kind;
    int depth;
    int faultAt;
    logic [7:0] a;
    for (int i = 0; i < MemWords; i++) begin
      mem[i] = $random(seed);
    end
    genPc = '0;
    emit(isaPkg::JmpC, regField(), regField(), CodeBase);
    genPc = SubBase;
    emit(aluOp(), regField(), regField(), '0);
    emit(isaPkg::Ret, regField(), regField(), '0);
    mem[MemWords-1] = {regField(), regField(), regField(), isaPkg::MovRC};  // Data word off the top
    genPc = CodeBase;
    genCount = 0;
    depth = 0;
    faultAt = withFault ? {$random(seed)} % ProgLen : ProgLen + 10;
    while (genCount < ProgLen) begin
      kind = {$random(seed)} % 10;
      a = regField();
      if (genCount >= faultAt) begin
        faultAt = ProgLen + 10;
        if (kind < 4) begin
          emit(isaPkg::JmpC, a, a, (MemWords - 1) * 4);
        end else begin
          emit(kind[0] ? isaPkg::MovRdC : isaPkg::MovdCR, a, regField(),
               (32'($random(seed)) | 32'h1000) & ~32'h3);
        end
      end else begin
        case (kind)
          0: emit(isaPkg::MovRC, a, regField(), $random(seed));
          1: emit(aluOp(), a, regField(), '0);
          2: emit(isaPkg::AddRRC, a, regField(), $random(seed));
          3: emit(isaPkg::MovRdC, a, regField(), DataBase + 4 * ({$random(seed)} % 256));
          4: emit(isaPkg::MovdCR, a, regField(), DataBase + 4 * ({$random(seed)} % 256));
          5: begin
            emit(isaPkg::PushR, a, regField(), '0);
            depth++;
          end
          6: begin
            if (depth > 0) begin
              emit(isaPkg::PopR, a, regField(), '0);
              depth--;
            end else begin
              emit(isaPkg::MovdCR, a, a, DataBase + 4 * ({$random(seed)} % 256));
            end
          end
          7: begin
            emit(isaPkg::CmpRR, a, ({$random(seed)} % 2) ? a : regField(), '0);  // Same reg forces equal
            emit(({$random(seed)} % 2) ? isaPkg::JeC : isaPkg::JneC, a, a, genPc + 12);
            emit(aluOp(), regField(), regField(), '0);  // Skipped when taken
          end
          8: begin
            emit(({$random(seed)} % 4) ? isaPkg::JzRC : isaPkg::JmpC, a, a, genPc + 12);
            emit(aluOp(), regField(), regField(), '0);
          end
          default: begin
            emit(isaPkg::MovRC, a, a, SubBase);
            emit(isaPkg::CallR, a, a, '0);
          end
        endcase
      end
    end
    mem[genPc[11:2]] = '0;  // Opcode 0 ends the program
  endtask

  // Records the request and performs it on the model memory
  function automatic bit modelAccess(input bit wr, input logic [31:0] addr,
                                     input logic [31:0] data, output logic [31:0] rd);
    expWrite.push_back(wr);
    expAddr.push_back(addr);
    expData.push_back(wr ? data : '0);
    rd = '0;
    if (addr >= MemWords * 4) begin
      return 1'b0;
    end
    if (wr) begin
      refMem[addr[11:2]] = data;
    end else begin
      rd = refMem[addr[11:2]];
    end
    return 1'b1;
  endfunction

  task automatic runModel();
    logic [31:0] regs [16];
    logic [31:0] ip, sp, dw, ad, ld, w, va, vb, vc, nextIp;
    logic [2:0] flags;
    logic [3:0] a;
    bit done;
    bit memOk;
    isaPkg::opcodeT op;
    ip = '0;
    sp = '0;
    flags = '0;
    done = 1'b0;
    foreach (regs[i]) begin
      regs[i] = '0;
    end
    for (int s = 0; s < 1000 && !done; s++) begin
      done = 1'b1;
      if (!modelAccess(1'b0, ip, '0, w)) begin
        expHaltCode = corePkg::BadInstrFetch;
        expHaltData = ip;
      end else if (w[7:0] == 8'd0 || w[7:0] > 8'(isaPkg::Ret)) begin
        expHaltCode = corePkg::BadOpcode;
        expHaltData = {24'd0, w[7:0]};
      end else if (isLongOp(isaPkg::opcodeT'(w[7:0])) && !modelAccess(1'b0, ip + 4, '0, dw)) begin
        expHaltCode = corePkg::BadDataFetch;
        expHaltData = ip + 4;
      end else begin
        done = 1'b0;
        op = isaPkg::opcodeT'(w[7:0]);
        a = w[11:8];
        va = regs[a];
        vb = regs[w[19:16]];
        vc = regs[w[27:24]];
        nextIp = ip + (isLongOp(op) ? 8 : 4);
        memOk = 1'b1;
        case (op)
          isaPkg::MovRC: regs[a] = dw;
          isaPkg::MovRR: regs[a] = vb;
          isaPkg::MovRdC: begin
            ad = dw;
            memOk = modelAccess(1'b0, ad, '0, ld);
            regs[a] = ld;
          end
          isaPkg::MovdCR: begin
            ad = dw;
            memOk = modelAccess(1'b1, ad, vb, ld);
          end
          isaPkg::PushR: begin
            ad = sp;
            memOk = modelAccess(1'b1, ad, va, ld);
            sp = sp + `STACK_STEP;
          end
          isaPkg::PopR: begin
            ad = sp - `STACK_STEP;
            memOk = modelAccess(1'b0, ad, '0, ld);
            regs[a] = ld;
            sp = ad;
          end
          isaPkg::AddRRC: regs[a] = vb + dw;
          isaPkg::AddRRR: regs[a] = vb + vc;
          isaPkg::SubRRR: regs[a] = vb - vc;
          isaPkg::ShlRRR: regs[a] = vb << vc;
          isaPkg::ShrRRR: regs[a] = vb >> vc;
          isaPkg::CmpRR: flags = {va > vb, va < vb, va == vb};
          isaPkg::JmpC: nextIp = dw;
          isaPkg::JeC: nextIp = flags[0] ? dw : nextIp;
          isaPkg::JneC: nextIp = flags[0] ? nextIp : dw;
          isaPkg::JzRC: nextIp = (va == 0) ? dw : nextIp;
          isaPkg::CallR: begin
            ad = sp;
            memOk = modelAccess(1'b1, ad, ip, ld);  // Return address is the call
            sp = sp + `STACK_STEP;
            nextIp = va;
          end
          default: begin  // Ret
            ad = sp - `STACK_STEP;
            memOk = modelAccess(1'b0, ad, '0, ld);
            sp = ad;
            nextIp = ld + 4;
          end
        endcase
        if (!memOk) begin
          done = 1'b1;
          expHaltCode = corePkg::BadMem;
          expHaltData = ad;
        end
        ip = nextIp;
      end
    end
  endtask

  // Request monitor and memory responder, inputs change on the falling edge
  always @(negedge clk) begin
    memStatus <= corePkg::MemIdle;
    if (reset) begin
      waitCount <= 0;
    end else if (memRead || memWrite) begin
      if (expAddr.size() == 0) begin
        $display("Memory request to %h that the model does not predict", memAddr);
        $display("RESULT: FAIL");
        $fatal(1, "Unexpected request");
      end else begin
        ew = expWrite.pop_front();
        ea = expAddr.pop_front();
        ed = expData.pop_front();
        compareValue("memWrite", ew, memWrite);
        compareValue("memAddr", ea, memAddr);
        if (memWrite) begin
          compareValue("memWData", ed, memWData);
        end
        reqWrite <= memWrite;
        reqAddr <= memAddr;
        reqData <= memWData;
        waitCount <= 1 + {$random(seed)} % 4;
      end
    end else if (waitCount == 1) begin
      waitCount <= 0;
      if (reqAddr >= MemWords * 4) begin
        memStatus <= corePkg::MemError;
      end else begin
        memStatus <= corePkg::MemReady;
        if (reqWrite) begin
          mem[reqAddr[11:2]] <= reqData;
        end else begin
          memRData <= mem[reqAddr[11:2]];
        end
      end
    end else if (waitCount > 1) begin
      waitCount <= waitCount - 1;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == TimeoutCycles) begin
      $display("Timeout after %0d cycles before all programs halted", cycles);
      $display("RESULT: FAIL");
      $fatal(1, "Timeout");
    end else if (u_cpuTop.u_chk.failCount != 0) begin
      $display("Protocol assertion failed before cycle %0d", cycles);
      $display("RESULT: FAIL");
      $fatal(1, "Assertion failure");
    end
  end

  initial begin
    seed = 32'hf82da492;
    reset = 1'b1;
    memStatus = corePkg::MemIdle;
    memRData = '0;
    for (int p = 0; p < Programs; p++) begin
      reset = 1'b1;
      buildProgram(p % 4 == 3);  // Every fourth program faults
      refMem = mem;
      runModel();
      repeat (ResetCycles) @(negedge clk);
      reset = 1'b0;
      while (!halted) begin
        @(negedge clk);
      end
      compareValue("haltCode", expHaltCode, haltCode);
      compareValue("haltData", expHaltData, haltData);
      repeat (8) @(negedge clk);  // Monitor trips on any late request
      compareValue("requestsLeft", 0, expAddr.size());
    end
    if (u_cpuTop.u_chk.failCount != 0) begin
      $display("Protocol assertions failed %0d times", u_cpuTop.u_chk.failCount);
      $display("RESULT: FAIL");
      $fatal(1, "Assertion failures");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

// ==== sim/cpuTop_chk.sv ====
`timescale 1ns/1ns

// Memory port protocol properties, bound into cpuTop
module cpuTop_chk (
  input logic clk,
  input logic reset,
  input logic memRead,
  input logic memWrite,
  input logic halted
);

  int failCount = 0;  // Read by the testbench at the end of the run

  // Read and write never share a cycle
  assert property (@(posedge clk) disable iff (reset) !(memRead && memWrite))
    else begin
      $error("memRead and memWrite high together");
      failCount++;
    end

  // Each request is a single-cycle pulse
  assert property (@(posedge clk) disable iff (reset) (memRead || memWrite) |=> !(memRead || memWrite))
    else begin
      $error("request held longer than one cycle");
      failCount++;
    end

  assert property (@(posedge clk) disable iff (reset) halted |-> !(memRead || memWrite))
    else begin
      $error("request issued while halted");
      failCount++;
    end

  // Async reset clears the request lines
  assert property (@(posedge clk) reset |-> !(memRead || memWrite))
    else begin
      $error("request line high during reset");
      failCount++;
    end

endmodule

// ==== hw/cpuTop.sv ====
`timescale 1ns/1ns
`include "cpu_config.svh"

// Core top, sequencer steering the register block and the execute unit
module cpuTop (
  input  logic                clk,
  input  logic                reset,
  output logic                memRead,
  output logic                memWrite,
  output logic [`WORD_W-1:0]  memAddr,
  output logic [`WORD_W-1:0]  memWData,
  input  corePkg::memStatusT  memStatus,
  input  logic [`WORD_W-1:0]  memRData,
  output logic                halted,
  output corePkg::haltCodeT   haltCode,
  output logic [`WORD_W-1:0]  haltData
);

  // Register block port
  logic [`REG_ADDR_W-1:0] rdIdxA, rdIdxB, rdIdxC, wrIdx;
  logic [`WORD_W-1:0]     valA, valB, valC, wrData, sp;
  logic                   wrEn, flagsWrEn;
  logic [2:0]             flagsIn, flags;
  logic [1:0]             spStep;

  // Execute unit operands and results
  isaPkg::opcodeT     opcode;
  logic [`WORD_W-1:0] dataWord, memData, ip, nextIp;
  logic [`WORD_W-1:0] result, accessAddr, storeData;
  logic [2:0]         flagsOut;
  logic [1:0]         opSpStep;
  logic               writesReg, setsFlags, takeJump, isLong, isLoad, isStore;

  instrSequencer u_instrSequencer (
    .clk, .reset, .memStatus, .memRData, .memRead, .memWrite, .memAddr, .memWData,
    .halted, .haltCode, .haltData,
    .rdIdxA, .rdIdxB, .rdIdxC, .wrEn, .wrIdx, .wrData, .flagsWrEn, .flagsIn, .spStep,
    .opcode, .dataWord, .memData, .ip,
    .result, .accessAddr, .storeData, .writesReg, .flagsOut, .setsFlags, .takeJump,
    .isLong, .isLoad, .isStore, .opSpStep, .nextIp
  );

  regBlock u_regBlock (
    .clk, .reset, .rdIdxA, .rdIdxB, .rdIdxC, .valA, .valB, .valC,
    .wrEn, .wrIdx, .wrData, .flagsWrEn, .flagsIn, .flags, .spStep, .sp
  );

  execUnit u_execUnit (
    .opcode, .valA, .valB, .valC, .dataWord, .memData, .sp, .ip, .flags,
    .result, .accessAddr, .storeData, .writesReg, .flagsOut, .setsFlags, .takeJump,
    .isLong, .isLoad, .isStore,
    .spStep (opSpStep),  // Applied by the sequencer in writeback
    .nextIp
  );

endmodule

// ==== hw/instrSequencer.sv ====
`timescale 1ns/1ns
`include "cpu_config.svh"

// Multi-cycle control FSM and memory port master
module instrSequencer (
  input  logic                   clk,
  input  logic                   reset,
  input  corePkg::memStatusT     memStatus,
  input  logic [`WORD_W-1:0]     memRData,
  output logic                   memRead,
  output logic                   memWrite,
  output logic [`WORD_W-1:0]     memAddr,
  output logic [`WORD_W-1:0]     memWData,
  output logic                   halted,
  output corePkg::haltCodeT      haltCode,
  output logic [`WORD_W-1:0]     haltData,
  output logic [`REG_ADDR_W-1:0] rdIdxA,
  output logic [`REG_ADDR_W-1:0] rdIdxB,
  output logic [`REG_ADDR_W-1:0] rdIdxC,
  output logic                   wrEn,
  output logic [`REG_ADDR_W-1:0] wrIdx,
  output logic [`WORD_W-1:0]     wrData,
  output logic                   flagsWrEn,
  output logic [2:0]             flagsIn,
  output logic [1:0]             spStep,
  output isaPkg::opcodeT         opcode,
  output logic [`WORD_W-1:0]     dataWord,
  output logic [`WORD_W-1:0]     memData,
  output logic [`WORD_W-1:0]     ip,
  input  logic [`WORD_W-1:0]     result,
  input  logic [`WORD_W-1:0]     accessAddr,
  input  logic [`WORD_W-1:0]     storeData,
  input  logic                   writesReg,
  input  logic [2:0]             flagsOut,
  input  logic                   setsFlags,
  input  logic                   takeJump,
  input  logic                   isLong,
  input  logic                   isLoad,
  input  logic                   isStore,
  input  logic [1:0]             opSpStep,
  input  logic [`WORD_W-1:0]     nextIp
);

  corePkg::seqStateT state;
  isaPkg::instrT     fetched;
  logic              reqPending;
  logic              respReady;
  logic              respError;
  logic              badOpcode;

  assign fetched    = memRData;
  assign reqPending = memRead | memWrite;  // Status is stale in the pulse cycle
  assign respReady  = !reqPending && (memStatus == corePkg::MemReady);
  assign respError  = !reqPending && (memStatus == corePkg::MemError);
  assign badOpcode  = (opcode == '0) || (opcode > isaPkg::MaxOpcode);

  assign halted = (state == corePkg::Halted);

  // Writeback strobes, one cycle each
  assign wrEn      = (state == corePkg::Writeback) && writesReg;
  assign wrIdx     = rdIdxA;  // Field A is always the destination
  assign wrData    = result;
  assign flagsWrEn = (state == corePkg::Writeback) && setsFlags;
  assign flagsIn   = flagsOut;
  assign spStep    = (state == corePkg::Writeback) ? opSpStep : 2'b00;

  // Control state and request pulses
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= corePkg::Fetch;
      ip       <= '0;
      memRead  <= 1'b0;
      memWrite <= 1'b0;
      haltCode <= corePkg::HaltNone;
    end else begin
      memRead  <= 1'b0;  // Pulses drop after one cycle
      memWrite <= 1'b0;
      case (state)
        corePkg::Fetch: begin
          memRead <= 1'b1;
          state   <= corePkg::FetchWait;
        end
        corePkg::FetchWait: begin
          if (respReady) begin
            state <= corePkg::RegRead;
          end else if (respError) begin
            state    <= corePkg::Halted;
            haltCode <= corePkg::BadInstrFetch;
          end
        end
        corePkg::RegRead: begin
          if (badOpcode) begin
            state    <= corePkg::Halted;
            haltCode <= corePkg::BadOpcode;
          end else if (isLong) begin
            memRead <= 1'b1;  // Data word at ip+4
            state   <= corePkg::DataWait;
          end else if (isLoad || isStore) begin
            state <= corePkg::MemAccess;
          end else begin
            state <= corePkg::Writeback;
          end
        end
        corePkg::DataWait: begin
          if (respReady) begin
            state <= (isLoad || isStore) ? corePkg::MemAccess : corePkg::Writeback;
          end else if (respError) begin
            state    <= corePkg::Halted;
            haltCode <= corePkg::BadDataFetch;
          end
        end
        corePkg::MemAccess: begin
          memRead  <= isLoad;
          memWrite <= isStore;
          state    <= corePkg::MemWait;
        end
        corePkg::MemWait: begin
          if (respReady) begin
            state <= corePkg::Writeback;
          end else if (respError) begin
            state    <= corePkg::Halted;
            haltCode <= corePkg::BadMem;
          end
        end
        corePkg::Writeback: begin
          if (takeJump) begin
            ip <= nextIp;
          end else begin
            ip <= ip + (isLong ? `LONG_INSTR_BYTES : `INSTR_BYTES);
          end
          state <= corePkg::Fetch;
        end
        default: state <= corePkg::Halted;  // Held until reset
      endcase
    end
  end

  // Address, data and latched instruction fields
  always_ff @(posedge clk) begin
    case (state)
      corePkg::Fetch: memAddr <= ip;
      corePkg::FetchWait: begin
        if (respReady) begin
          opcode <= fetched.opcode;
          rdIdxA <= fetched.regA[`REG_ADDR_W-1:0];
          rdIdxB <= fetched.regB[`REG_ADDR_W-1:0];
          rdIdxC <= fetched.regC[`REG_ADDR_W-1:0];
        end else if (respError) begin
          haltData <= memAddr;
        end
      end
      corePkg::RegRead: begin
        if (badOpcode) begin
          haltData <= {{(`WORD_W-`OP_W){1'b0}}, opcode};  // Report the code
        end else begin
          memAddr <= ip + `INSTR_BYTES;
        end
      end
      corePkg::DataWait: begin
        if (respReady) begin
          dataWord <= memRData;
        end else if (respError) begin
          haltData <= memAddr;
        end
      end
      corePkg::MemAccess: begin
        memAddr  <= accessAddr;
        memWData <= storeData;
      end
      corePkg::MemWait: begin
        if (respReady) begin
          memData <= memRData;  // Ignored by stores
        end else if (respError) begin
          haltData <= memAddr;
        end
      end
      default: ;
    endcase
  end

endmodule

// ==== hw/execUnit.sv ====
`timescale 1ns/1ns
`include "cpu_config.svh"

// Combinational decode and datapath for the latched instruction
module execUnit (
  input  isaPkg::opcodeT      opcode,
  input  logic [`WORD_W-1:0]  valA,
  input  logic [`WORD_W-1:0]  valB,
  input  logic [`WORD_W-1:0]  valC,
  input  logic [`WORD_W-1:0]  dataWord,   // Second word of long opcodes
  input  logic [`WORD_W-1:0]  memData,    // Loaded word
  input  logic [`WORD_W-1:0]  sp,
  input  logic [`WORD_W-1:0]  ip,
  input  logic [2:0]          flags,
  output logic [`WORD_W-1:0]  result,
  output logic [`WORD_W-1:0]  accessAddr,
  output logic [`WORD_W-1:0]  storeData,
  output logic                writesReg,
  output logic [2:0]          flagsOut,
  output logic                setsFlags,
  output logic                takeJump,   // ip leaves the straight line
  output logic                isLong,
  output logic                isLoad,
  output logic                isStore,
  output logic [1:0]          spStep,
  output logic [`WORD_W-1:0]  nextIp      // Redirect target when takeJump
);

  always_comb begin
    // Defaults for opcodes that leave a field alone
    result     = memData;
    accessAddr = dataWord;
    storeData  = valB;
    writesReg  = 1'b0;
    flagsOut   = {(valA > valB), (valA < valB), (valA == valB)};  // Unsigned compare
    setsFlags  = 1'b0;
    takeJump   = 1'b0;
    isLong     = 1'b0;
    isLoad     = 1'b0;
    isStore    = 1'b0;
    spStep     = 2'b00;
    nextIp     = dataWord;

    case (opcode)
      isaPkg::MovRC:  begin result = dataWord; writesReg = 1'b1; isLong = 1'b1; end
      isaPkg::MovRR:  begin result = valB; writesReg = 1'b1; end
      isaPkg::MovRdC: begin writesReg = 1'b1; isLong = 1'b1; isLoad = 1'b1; end
      isaPkg::MovdCR: begin isLong = 1'b1; isStore = 1'b1; end
      isaPkg::PushR: begin
        accessAddr = sp;  // Post increment
        storeData  = valA;
        isStore    = 1'b1;
        spStep     = 2'b01;
      end
      isaPkg::PopR: begin
        accessAddr = sp - `STACK_STEP;  // Top of stack
        writesReg  = 1'b1;
        isLoad     = 1'b1;
        spStep     = 2'b10;
      end
      isaPkg::AddRRC: begin result = valB + dataWord; writesReg = 1'b1; isLong = 1'b1; end
      isaPkg::AddRRR: begin result = valB + valC; writesReg = 1'b1; end
      isaPkg::SubRRR: begin result = valB - valC; writesReg = 1'b1; end
      isaPkg::ShlRRR: begin result = valB << valC; writesReg = 1'b1; end  // Logical
      isaPkg::ShrRRR: begin result = valB >> valC; writesReg = 1'b1; end
      isaPkg::CmpRR:  setsFlags = 1'b1;
      isaPkg::JmpC:   begin takeJump = 1'b1; isLong = 1'b1; end
      isaPkg::JeC:    begin takeJump = flags[0]; isLong = 1'b1; end
      isaPkg::JneC:   begin takeJump = !flags[0]; isLong = 1'b1; end
      isaPkg::JzRC:   begin takeJump = (valA == '0); isLong = 1'b1; end
      isaPkg::CallR: begin
        accessAddr = sp;
        storeData  = ip;  // Return address is the call itself
        isStore    = 1'b1;
        spStep     = 2'b01;
        takeJump   = 1'b1;
        nextIp     = valA;
      end
      isaPkg::Ret: begin
        accessAddr = sp - `STACK_STEP;
        isLoad     = 1'b1;
        spStep     = 2'b10;
        takeJump   = 1'b1;
        nextIp     = memData + `INSTR_BYTES;  // Skip the CallR
      end
      default: ;  // Invalid codes trapped by the sequencer
    endcase
  end

endmodule

// ==== hw/regBlock.sv ====
`timescale 1ns/1ns
`include "cpu_config.svh"

// General registers, flags and stack pointer
module regBlock (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`REG_ADDR_W-1:0] rdIdxA,
  input  logic [`REG_ADDR_W-1:0] rdIdxB,
  input  logic [`REG_ADDR_W-1:0] rdIdxC,
  output logic [`WORD_W-1:0]     valA,
  output logic [`WORD_W-1:0]     valB,
  output logic [`WORD_W-1:0]     valC,
  input  logic                   wrEn,
  input  logic [`REG_ADDR_W-1:0] wrIdx,
  input  logic [`WORD_W-1:0]     wrData,
  input  logic                   flagsWrEn,
  input  logic [2:0]             flagsIn,    // {gt, lt, eq}
  output logic [2:0]             flags,
  input  logic [1:0]             spStep,     // Bit 0 steps up, bit 1 steps down
  output logic [`WORD_W-1:0]     sp
);

  logic [`WORD_W-1:0] regs [`REG_COUNT];

  // Three async read ports
  assign valA = regs[rdIdxA];
  assign valB = regs[rdIdxB];
  assign valC = regs[rdIdxC];

  // Register file, cleared on reset
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn) begin
      regs[wrIdx] <= wrData;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      flags <= 3'b000;
    end else if (flagsWrEn) begin
      flags <= flagsIn;  // Only CmpRR writes
    end
  end

  // Stack pointer
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      sp <= '0;
    end else if (spStep[0]) begin
      sp <= sp + `STACK_STEP;  // Push or call
    end else if (spStep[1]) begin
      sp <= sp - `STACK_STEP;  // Pop or return
    end
  end

endmodule

// ==== hw/corePkg.sv ====
package corePkg;

  // Sequencer FSM
  typedef enum logic [2:0] {
    Fetch, FetchWait, RegRead, DataWait, MemAccess, MemWait, Writeback, Halted
  } seqStateT;

  // Status returned by the memory after a request pulse
  typedef enum logic [1:0] {
    MemIdle  = 2'd0,  // Still busy
    MemReady = 2'd1,
    MemError = 2'd2
  } memStatusT;

  // Reason reported on halt
  typedef enum logic [7:0] {
    HaltNone = 8'd0, BadInstrFetch = 8'd1, BadDataFetch = 8'd2,
    BadMem = 8'd3, BadOpcode = 8'd4
  } haltCodeT;

endpackage

// ==== hw/isaPkg.sv ====
`include "cpu_config.svh"

package isaPkg;

  // Opcode byte of every instruction, zero never decodes
  typedef enum logic [`OP_W-1:0] {
    MovRC = 1,  // A = data word
    MovRR,      // A = B
    MovRdC,     // A = mem[data word]
    MovdCR,     // mem[data word] = B
    PushR,      // mem[SP] = A, SP up
    PopR,       // SP down, A = mem[SP]
    AddRRC,     // A = B + data word
    AddRRR,     // A = B + C
    SubRRR,     // A = B - C
    ShlRRR,     // A = B << C
    ShrRRR,     // A = B >> C
    CmpRR,      // Flags from unsigned A vs B
    JmpC,       // ip = data word
    JeC,        // Jump when equal flag set
    JneC,       // Jump when equal flag clear
    JzRC,       // Jump when A is zero
    CallR,      // Push ip, jump to A
    Ret         // Pop return ip, resume after the call
  } opcodeT;

  // Highest legal code
  localparam opcodeT MaxOpcode = Ret;

  // Register field byte
  typedef logic [7:0] regFieldT;

  // First instruction word, byte 0 holds the opcode
  typedef struct packed {
    regFieldT regC;    // Byte 3
    regFieldT regB;    // Byte 2
    regFieldT regA;    // Byte 1
    opcodeT   opcode;  // Byte 0
  } instrT;

endpackage

// ==== hw/cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Datapath and address width
`define WORD_W 32
// Opcode byte
`define OP_W 8

// General register file
`define REG_COUNT 16
`define REG_ADDR_W 4

// Stack grows upward one word per push
`define STACK_STEP 4

// Instruction lengths in bytes
`define INSTR_BYTES 4
`define LONG_INSTR_BYTES 8

`endif
